//--- hdl/mbox_cfg.svh
`ifndef MBOX_CFG_SVH
`define MBOX_CFG_SVH

// ======================================================================
// Cluster size and mailbox geometry
// ======================================================================

// Number of cores, one mailbox each
`define MBOX_N_CORES 4

// Entries per mailbox FIFO
`define MBOX_DEPTH 8

// Message width in bits
`define MBOX_DATA_W 64

// Boot timing, in system clock cycles
`define BOOT_RESET_CYCLES 100
`define BOOT_STAGGER_CYCLES 10

`endif

//--- hdl/mbox_pkg.sv
`include "mbox_cfg.svh"

package mbox_pkg;

	// Core index, also the mailbox index
	typedef logic [$clog2(`MBOX_N_CORES)-1:0] core_id_t;

	// One mailbox message
	typedef logic [`MBOX_DATA_W-1:0] msg_data_t;

	// One bit per core
	typedef logic [`MBOX_N_CORES-1:0] core_mask_t;

	// Boot sequencer states
	typedef enum logic [1:0] {
		BOOT_RESET_WAIT,
		BOOT_STAGGER,
		BOOT_ALL_RUNNING
	} boot_state_t;

	// Read arbiter output register state
	typedef enum logic {
		ARB_IDLE,
		ARB_HOLD
	} arb_state_t;

endpackage

//--- hdl/boot_sequencer.sv
`timescale 1ns/10ps
`include "mbox_cfg.svh"

module boot_sequencer (
	input  logic                i_sys_clk,
	input  logic                i_sys_rst_n,
	output mbox_pkg::core_mask_t o_core_enable
);

	localparam int CNT_W = $clog2(`BOOT_RESET_CYCLES + `BOOT_STAGGER_CYCLES + 1);

	mbox_pkg::boot_state_t state;
	logic [CNT_W-1:0]      cnt;
	mbox_pkg::core_id_t    core_idx;
	logic                  fire;
	logic                  last_core;

	// Time to release the core selected by core_idx
	always_comb begin
		case (state)
			mbox_pkg::BOOT_RESET_WAIT: fire = (cnt == CNT_W'(`BOOT_RESET_CYCLES));
			mbox_pkg::BOOT_STAGGER:    fire = (cnt == CNT_W'(`BOOT_STAGGER_CYCLES - 1));
			default:                   fire = 1'b0;
		endcase
	end

	assign last_core = (core_idx == mbox_pkg::core_id_t'(`MBOX_N_CORES - 1));

	// ======================================================================
	// Staggered enable FSM
	// ======================================================================
	always_ff @(posedge i_sys_clk or negedge i_sys_rst_n) begin
		if (!i_sys_rst_n) begin
			state         <= mbox_pkg::BOOT_RESET_WAIT;
			cnt           <= '0;
			core_idx      <= '0;
			o_core_enable <= '0;
		end else if (fire) begin
			o_core_enable[core_idx] <= 1'b1;
			cnt                     <= '0;
			if (last_core) begin
				state <= mbox_pkg::BOOT_ALL_RUNNING;
			end else begin
				core_idx <= core_idx + 1'b1;
				state    <= mbox_pkg::BOOT_STAGGER;
			end
		end else if (state != mbox_pkg::BOOT_ALL_RUNNING) begin
			cnt <= cnt + 1'b1;
		end
	end

	// Cores never drop back into reset once released
	a_enable_monotonic: assert property (
		@(posedge i_sys_clk) disable iff (!i_sys_rst_n)
		((o_core_enable & $past(o_core_enable)) == $past(o_core_enable))
	) else $error("core enable mask lost a bit");

endmodule

//--- hdl/mbox_write_router.sv
`timescale 1ns/10ps
`include "mbox_cfg.svh"

module mbox_write_router (
	input  logic                 i_sys_clk,
	input  logic                 i_sys_rst_n,
	input  logic                 i_wr_valid,
	input  mbox_pkg::core_id_t   i_wr_dest,
	input  mbox_pkg::msg_data_t  i_wr_data,
	output logic                 o_wr_ready,
	output mbox_pkg::core_mask_t o_push_valid,
	output mbox_pkg::msg_data_t  o_push_data,
	input  mbox_pkg::core_mask_t i_push_ready
);

	logic                hold_valid;
	mbox_pkg::core_id_t  hold_dest;
	mbox_pkg::msg_data_t hold_data;
	logic                wr_fire;
	logic                push_fire;

	// Steer the held message to its destination only
	always_comb begin
		o_push_valid = '0;
		if (hold_valid)
			o_push_valid[hold_dest] = 1'b1;
	end

	assign push_fire   = |(o_push_valid & i_push_ready);
	assign o_wr_ready  = !hold_valid || push_fire;
	assign wr_fire     = i_wr_valid && o_wr_ready;
	assign o_push_data = hold_data;

	always_ff @(posedge i_sys_clk or negedge i_sys_rst_n) begin
		if (!i_sys_rst_n)
			hold_valid <= 1'b0;
		else if (wr_fire)
			hold_valid <= 1'b1;
		else if (push_fire)
			hold_valid <= 1'b0;
	end

	always_ff @(posedge i_sys_clk) begin
		if (wr_fire) begin
			hold_dest <= i_wr_dest;
			hold_data <= i_wr_data;
		end
	end

	a_push_onehot: assert property (
		@(posedge i_sys_clk) disable iff (!i_sys_rst_n) $onehot0(o_push_valid)
	) else $error("push valid to more than one mailbox");

endmodule

//--- hdl/mbox_fifo.sv
`timescale 1ns/10ps
`include "mbox_cfg.svh"

module mbox_fifo (
	input  logic                i_sys_clk,
	input  logic                i_sys_rst_n,
	input  logic                i_core_en,
	input  logic                i_push_valid,
	input  mbox_pkg::msg_data_t i_push_data,
	output logic                o_push_ready,
	output logic                o_pop_valid,
	output mbox_pkg::msg_data_t o_pop_data,
	input  logic                i_pop_ready
);

	localparam int PTR_W = $clog2(`MBOX_DEPTH);
	localparam int CNT_W = $clog2(`MBOX_DEPTH + 1);

	mbox_pkg::msg_data_t mem [0:`MBOX_DEPTH-1];
	logic [PTR_W-1:0]    wr_ptr;
	logic [PTR_W-1:0]    rd_ptr;
	logic [CNT_W-1:0]    count;
	logic                push;
	logic                pop;

	// Disabled core accepts nothing, so its mailbox stays empty
	assign o_push_ready = i_core_en && (count != CNT_W'(`MBOX_DEPTH));
	assign o_pop_valid  = (count != '0);
	assign o_pop_data   = mem[rd_ptr];

	assign push = i_push_valid && o_push_ready;
	assign pop  = i_pop_ready && o_pop_valid;

	// ======================================================================
	// Pointers and occupancy
	// ======================================================================
	always_ff @(posedge i_sys_clk or negedge i_sys_rst_n) begin
		if (!i_sys_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(`MBOX_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(`MBOX_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Message storage
	always_ff @(posedge i_sys_clk) begin
		if (push)
			mem[wr_ptr] <= i_push_data;
	end

	// A refused push is retried with the same message
	a_no_push_when_not_ready: assert property (
		@(posedge i_sys_clk) disable iff (!i_sys_rst_n)
		(i_push_valid && !o_push_ready) |=> (i_push_valid && $stable(i_push_data))
	) else $error("refused push was dropped or changed");

	// Arbiter only grants mailboxes that hold data
	a_no_pop_when_empty: assert property (
		@(posedge i_sys_clk) disable iff (!i_sys_rst_n)
		i_pop_ready |-> o_pop_valid
	) else $error("pop from empty mailbox");

endmodule

//--- hdl/mbox_read_arbiter.sv
`timescale 1ns/10ps
`include "mbox_cfg.svh"

module mbox_read_arbiter (
	input  logic                 i_sys_clk,
	input  logic                 i_sys_rst_n,
	input  mbox_pkg::core_mask_t i_pop_valid,
	input  mbox_pkg::msg_data_t  i_pop_data [0:`MBOX_N_CORES-1],
	output mbox_pkg::core_mask_t o_pop_ready,
	output logic                 o_rd_valid,
	output mbox_pkg::core_id_t   o_rd_src,
	output mbox_pkg::msg_data_t  o_rd_data,
	input  logic                 i_rd_ready
);

	mbox_pkg::arb_state_t state;
	mbox_pkg::core_id_t   rr_ptr;
	mbox_pkg::core_id_t   grant_idx;
	logic                 grant_found;
	logic                 load_en;

	// ======================================================================
	// Round-robin search, starting after the last granted mailbox
	// ======================================================================
	always_comb begin
		mbox_pkg::core_id_t cand;
		grant_found = 1'b0;
		grant_idx   = rr_ptr;
		for (int i = 1; i <= `MBOX_N_CORES; i++) begin
			cand = mbox_pkg::core_id_t'((int'(rr_ptr) + i) % `MBOX_N_CORES);
			if (!grant_found && i_pop_valid[cand]) begin
				grant_found = 1'b1;
				grant_idx   = cand;
			end
		end
	end

	// Output register free now or emptied this cycle
	assign o_rd_valid = (state == mbox_pkg::ARB_HOLD);
	assign load_en    = !o_rd_valid || i_rd_ready;

	always_comb begin
		o_pop_ready = '0;
		if (load_en && grant_found)
			o_pop_ready[grant_idx] = 1'b1;
	end

	always_ff @(posedge i_sys_clk or negedge i_sys_rst_n) begin
		if (!i_sys_rst_n) begin
			state  <= mbox_pkg::ARB_IDLE;
			rr_ptr <= mbox_pkg::core_id_t'(`MBOX_N_CORES - 1);
		end else if (load_en) begin
			if (grant_found) begin
				state  <= mbox_pkg::ARB_HOLD;
				rr_ptr <= grant_idx;
			end else begin
				state <= mbox_pkg::ARB_IDLE;
			end
		end
	end

	// Output payload
	always_ff @(posedge i_sys_clk) begin
		if (load_en && grant_found) begin
			o_rd_src  <= grant_idx;
			o_rd_data <= i_pop_data[grant_idx];
		end
	end

	a_pop_onehot: assert property (
		@(posedge i_sys_clk) disable iff (!i_sys_rst_n) $onehot0(o_pop_ready)
	) else $error("more than one mailbox popped");

	a_rd_stable: assert property (
		@(posedge i_sys_clk) disable iff (!i_sys_rst_n)
		(o_rd_valid && !i_rd_ready) |=>
			(o_rd_valid && $stable(o_rd_data) && $stable(o_rd_src))
	) else $error("read output changed while stalled");

endmodule

//--- hdl/cluster_mailbox_top.sv
`timescale 1ns/10ps
`include "mbox_cfg.svh"

module cluster_mailbox_top (
	input  logic                 i_sys_clk,
	input  logic                 i_sys_rst_n,

	// Message write port
	input  logic                 i_wr_valid,
	input  mbox_pkg::core_id_t   i_wr_dest,
	input  mbox_pkg::msg_data_t  i_wr_data,
	output logic                 o_wr_ready,

	// Mailbox drain port
	output logic                 o_rd_valid,
	output mbox_pkg::core_id_t   o_rd_src,
	output mbox_pkg::msg_data_t  o_rd_data,
	input  logic                 i_rd_ready,

	// Per-core status
	output mbox_pkg::core_mask_t o_mbox_irq,
	output mbox_pkg::core_mask_t o_core_enable
);

	mbox_pkg::core_mask_t core_enable;
	mbox_pkg::core_mask_t push_valid;
	mbox_pkg::msg_data_t  push_data;
	mbox_pkg::core_mask_t push_ready;
	mbox_pkg::core_mask_t pop_valid;
	mbox_pkg::msg_data_t  pop_data [0:`MBOX_N_CORES-1];
	mbox_pkg::core_mask_t pop_ready;

	// ======================================================================
	// Boot and write side
	// ======================================================================
	boot_sequencer u_boot_seq (
		.i_sys_clk     (i_sys_clk),
		.i_sys_rst_n   (i_sys_rst_n),
		.o_core_enable (core_enable)
	);

	mbox_write_router u_wr_router (
		.i_sys_clk    (i_sys_clk),
		.i_sys_rst_n  (i_sys_rst_n),
		.i_wr_valid   (i_wr_valid),
		.i_wr_dest    (i_wr_dest),
		.i_wr_data    (i_wr_data),
		.o_wr_ready   (o_wr_ready),
		.o_push_valid (push_valid),
		.o_push_data  (push_data),
		.i_push_ready (push_ready)
	);

	// One mailbox per core
	for (genvar i = 0; i < `MBOX_N_CORES; i++) begin : g_mbox
		mbox_fifo u_fifo (
			.i_sys_clk    (i_sys_clk),
			.i_sys_rst_n  (i_sys_rst_n),
			.i_core_en    (core_enable[i]),
			.i_push_valid (push_valid[i]),
			.i_push_data  (push_data),
			.o_push_ready (push_ready[i]),
			.o_pop_valid  (pop_valid[i]),
			.o_pop_data   (pop_data[i]),
			.i_pop_ready  (pop_ready[i])
		);
	end

	// ======================================================================
	// Drain side
	// ======================================================================
	mbox_read_arbiter u_rd_arb (
		.i_sys_clk   (i_sys_clk),
		.i_sys_rst_n (i_sys_rst_n),
		.i_pop_valid (pop_valid),
		.i_pop_data  (pop_data),
		.o_pop_ready (pop_ready),
		.o_rd_valid  (o_rd_valid),
		.o_rd_src    (o_rd_src),
		.o_rd_data   (o_rd_data),
		.i_rd_ready  (i_rd_ready)
	);

	// Interrupt while a mailbox holds data
	assign o_mbox_irq    = pop_valid;
	assign o_core_enable = core_enable;

endmodule

//--- verif/tb_cluster_mailbox.sv
`timescale 1ns/10ps
`include "mbox_cfg.svh"

module tb_cluster_mailbox;

	// Boot takes about 150 cycles and the traffic phases a few hundred more
	localparam int TIMEOUT_CYCLES = 3000;
	localparam int N_RANDOM       = 60;
	localparam mbox_pkg::core_id_t FILL_DEST = mbox_pkg::core_id_t'(1);

	logic                 i_sys_clk = 1'b0;
	logic                 i_sys_rst_n;
	logic                 i_wr_valid;
	mbox_pkg::core_id_t   i_wr_dest;
	mbox_pkg::msg_data_t  i_wr_data;
	logic                 o_wr_ready;
	logic                 o_rd_valid;
	mbox_pkg::core_id_t   o_rd_src;
	mbox_pkg::msg_data_t  o_rd_data;
	logic                 i_rd_ready;
	mbox_pkg::core_mask_t o_mbox_irq;
	mbox_pkg::core_mask_t o_core_enable;

	// Scoreboard, one queue per destination
	mbox_pkg::msg_data_t  exp_q [`MBOX_N_CORES][$];
	int                   pend_cnt [`MBOX_N_CORES] = '{default: 0};
	mbox_pkg::msg_data_t  head_data [`MBOX_N_CORES];
	int                   pending_total = 0;
	mbox_pkg::core_id_t   last_dest = '0;
	logic                 accept_seen = 1'b0;
	int                   fill_cnt = 0;
	mbox_pkg::core_id_t   hist [3];
	int                   hist_n = 0;
	mbox_pkg::core_mask_t recent_mask = '0;

	// Stimulus phase flags
	logic rd_random;
	logic fill_phase;
	logic rr_check;
	int   boot_cnt;
	int   cycle_cnt = 0;

	cluster_mailbox_top dut (.*);

	always #5 i_sys_clk = ~i_sys_clk;

	// Rising edges since reset release, same reference as the boot counter
	always @(posedge i_sys_clk or negedge i_sys_rst_n) begin
		if (!i_sys_rst_n)
			boot_cnt <= 0;
		else
			boot_cnt <= boot_cnt + 1;
	end

	function automatic mbox_pkg::core_mask_t expected_enable(input int cnt);
		mbox_pkg::core_mask_t m;
		m = '0;
		for (int k = 0; k < `MBOX_N_CORES; k++)
			m[k] = (cnt > `BOOT_RESET_CYCLES + k * `BOOT_STAGGER_CYCLES);
		return m;
	endfunction

	task automatic report_error(input string msg);
		$display("[ERROR] %0t: %s", $time, msg);
		$display("** FAIL **");
		$fatal(1, "check failed");
	endtask

	task automatic step();
		@(posedge i_sys_clk);
		if (rd_random)
			i_rd_ready <= ($urandom % 4) != 0;
	endtask

	task automatic wait_accept();
		step();
		while (!o_wr_ready)
			step();
		i_wr_valid <= 1'b0;
	endtask

	task automatic send_msg(input mbox_pkg::core_id_t dest, input mbox_pkg::msg_data_t data);
		i_wr_valid <= 1'b1;
		i_wr_dest  <= dest;
		i_wr_data  <= data;
		wait_accept();
	endtask

	// Scoreboard counters are read between edges only
	task automatic wait_drain();
		@(negedge i_sys_clk);
		while (pending_total != 0) begin
			step();
			@(negedge i_sys_clk);
		end
		@(posedge i_sys_clk);
	endtask

	// ======================================================================
	// Scoreboard update on every handshake
	// ======================================================================
	always @(posedge i_sys_clk) begin
		if (i_wr_valid && o_wr_ready) begin
			exp_q[i_wr_dest].push_back(i_wr_data);
			last_dest   = i_wr_dest;
			accept_seen = 1'b1;
			if (fill_phase && i_wr_dest == FILL_DEST)
				fill_cnt++;
		end
		if (o_rd_valid && i_rd_ready) begin
			if (exp_q[o_rd_src].size() != 0)
				void'(exp_q[o_rd_src].pop_front());
			if (rr_check) begin
				hist[2] = hist[1];
				hist[1] = hist[0];
				hist[0] = o_rd_src;
				if (hist_n < 3)
					hist_n++;
			end
		end
		if (!rr_check)
			hist_n = 0;
		recent_mask = '0;
		for (int i = 0; i < hist_n; i++)
			recent_mask[hist[i]] = 1'b1;
		pending_total = 0;
		for (int k = 0; k < `MBOX_N_CORES; k++) begin
			pend_cnt[k]   = exp_q[k].size();
			head_data[k]  = (exp_q[k].size() != 0) ? exp_q[k][0] : '0;
			pending_total += pend_cnt[k];
		end
	end

	// ======================================================================
	// Checks
	// ======================================================================
	a_reset_quiet: assert property (@(posedge i_sys_clk)
		!i_sys_rst_n |-> (o_core_enable == '0 && o_mbox_irq == '0 && !o_rd_valid && o_wr_ready)
	) else report_error("outputs not idle during reset");

	a_boot_timing: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst_n)
		o_core_enable == expected_enable(boot_cnt)
	) else report_error($sformatf("core enable %b at boot cycle %0d",
		$sampled(o_core_enable), $sampled(boot_cnt)));

	a_read_data: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst_n)
		(o_rd_valid && i_rd_ready) |->
			(pend_cnt[o_rd_src] != 0 && o_rd_data == head_data[o_rd_src])
	) else report_error($sformatf("unexpected read from core %0d, data %h",
		$sampled(o_rd_src), $sampled(o_rd_data)));

	a_read_enabled: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst_n)
		o_rd_valid |-> o_core_enable[o_rd_src]
	) else report_error("message delivered from a core still in reset");

	a_irq_disabled: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst_n)
		(o_mbox_irq & ~o_core_enable) == '0
	) else report_error($sformatf("irq %b with enable %b",
		$sampled(o_mbox_irq), $sampled(o_core_enable)));

	// Router holds at most one message, so two pending means the FIFO has one
	for (genvar k = 0; k < `MBOX_N_CORES; k++) begin : g_irq_chk
		a_irq_high: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst_n)
			(pend_cnt[k] - int'(o_rd_valid && o_rd_src == k) >= 2) |-> o_mbox_irq[k]
		) else report_error($sformatf("irq %0d low with messages waiting", k));

		a_irq_low: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst_n)
			(pend_cnt[k] - int'(o_rd_valid && o_rd_src == k) == 0) |-> !o_mbox_irq[k]
		) else report_error($sformatf("irq %0d high with mailbox empty", k));
	end

	a_router_stall: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst_n)
		(accept_seen && !o_core_enable[last_dest]) |-> !o_wr_ready
	) else report_error("write ready while router holds a message for a disabled core");

	a_fill_ready: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst_n)
		(fill_phase && !i_rd_ready && i_wr_valid) |->
			(o_wr_ready == (fill_cnt < `MBOX_DEPTH + 1))
	) else report_error($sformatf("write ready %b after %0d messages to a stalled mailbox",
		$sampled(o_wr_ready), $sampled(fill_cnt)));

	a_rr_distinct: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst_n)
		(rr_check && o_rd_valid && i_rd_ready) |-> !recent_mask[o_rd_src]
	) else report_error($sformatf("core %0d read again within four reads",
		$sampled(o_rd_src)));

	always @(posedge i_sys_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("** FAIL **");
			$fatal(1, "timeout");
		end
	end

	// ======================================================================
	// Stimulus
	// ======================================================================
	initial begin
		void'($urandom(38183));
		i_sys_rst_n <= 1'b0;
		i_wr_valid  <= 1'b0;
		i_wr_dest   <= '0;
		i_wr_data   <= '0;
		i_rd_ready  <= 1'b1;
		rd_random   <= 1'b0;
		fill_phase  <= 1'b0;
		rr_check    <= 1'b0;
		repeat (16) @(posedge i_sys_clk);
		i_sys_rst_n <= 1'b1;
		repeat (20) step();

		// Two messages to core 3 while it is still in reset
		send_msg(2'd3, {$urandom, $urandom});
		send_msg(2'd3, {$urandom, $urandom});
		wait_drain();

		// Random traffic with a random reader
		rd_random <= 1'b1;
		for (int i = 0; i < N_RANDOM; i++) begin
			send_msg(mbox_pkg::core_id_t'($urandom % `MBOX_N_CORES), {$urandom, $urandom});
			if ($urandom % 4 == 0)
				step();
		end
		wait_drain();

		// Reader stalled, output register taken by core 0, then fill one mailbox
		rd_random  <= 1'b0;
		i_rd_ready <= 1'b0;
		send_msg(2'd0, {$urandom, $urandom});
		while (!o_rd_valid)
			step();
		fill_phase <= 1'b1;
		for (int i = 0; i < `MBOX_DEPTH + 1; i++)
			send_msg(FILL_DEST, {$urandom, $urandom});
		i_wr_valid <= 1'b1;
		i_wr_dest  <= FILL_DEST;
		i_wr_data  <= {$urandom, $urandom};
		repeat (6) step();
		fill_phase <= 1'b0;
		i_rd_ready <= 1'b1;
		wait_accept();
		wait_drain();

		// Three per mailbox, then drain at full rate
		i_rd_ready <= 1'b0;
		for (int r = 0; r < 3; r++) begin
			for (int k = 0; k < `MBOX_N_CORES; k++)
				send_msg(mbox_pkg::core_id_t'(k), {$urandom, $urandom});
		end
		repeat (3) step();
		rr_check   <= 1'b1;
		i_rd_ready <= 1'b1;
		wait_drain();
		rr_check <= 1'b0;

		@(negedge i_sys_clk);
		if (pending_total == 0 && !o_rd_valid) begin
			$display("** PASS **");
			$finish;
		end else begin
			report_error("messages left undelivered at the end of the run");
		end
	end

endmodule

//--- cluster_mailbox.f
+incdir+hdl
hdl/mbox_pkg.sv
hdl/boot_sequencer.sv
hdl/mbox_write_router.sv
hdl/mbox_fifo.sv
hdl/mbox_read_arbiter.sv
hdl/cluster_mailbox_top.sv
verif/tb_cluster_mailbox.sv
